//--- Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module tb_core_platform -o Vtb

run: build
	./obj_dir/Vtb | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module core_platform_top

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/core_counters.sv
// Memory mapped machine timer. Holds the 64-bit mtime and mtimecmp,
// serves word reads and byte-lane writes one cycle after the strobe,
// and raises the timer interrupt level while mtime >= mtimecmp.
`timescale 1ns/1ps
`include "core_params.svh"

module core_counters (
    input  logic                   g_clk,
    input  logic                   i_reset,
    input  logic                   i_mmio_req,   // Held until gnt
    input  logic                   i_mmio_wen,
    input  logic [3:0]             i_mmio_off,
    input  logic [`MEM_DATA_W-1:0] i_mmio_wdata,
    input  logic [`MEM_STRB_W-1:0] i_mmio_strb,
    output logic                   o_mmio_gnt,
    output logic                   o_mmio_err,
    output logic [`MEM_DATA_W-1:0] o_mmio_rdata,
    output logic                   o_timer_int   // mtime >= mtimecmp
);

    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;
    logic                   access;     // First cycle of a strobe
    logic                   misaligned; // Not a word access
    logic                   wr_ok;      // Legal write this cycle
    logic [`MEM_DATA_W-1:0] rd_word;    // Addressed register half

    // Merge write data into an old word by byte lane
    function automatic logic [`MEM_DATA_W-1:0] merge_lanes(
        input logic [`MEM_DATA_W-1:0] old_word,
        input logic [`MEM_DATA_W-1:0] new_word,
        input logic [`MEM_STRB_W-1:0] strb
    );
        logic [`MEM_DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < `MEM_STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // ----------------------------------------
    // Access decode
    assign access     = i_mmio_req && !o_mmio_gnt; // Gnt cycle is not a new access
    assign misaligned = |i_mmio_off[1:0];
    assign wr_ok      = access && i_mmio_wen && !misaligned;

    always_comb begin
        case (i_mmio_off)
            `MTIME_LO_OFF:    rd_word = mtime[31:0];
            `MTIME_HI_OFF:    rd_word = mtime[63:32];
            `MTIMECMP_LO_OFF: rd_word = mtimecmp[31:0];
            `MTIMECMP_HI_OFF: rd_word = mtimecmp[63:32];
            default:          rd_word = '0; // Misaligned offsets read zero
        endcase
    end

    // ----------------------------------------
    // Timer registers

    // Free running except in a cycle that writes it
    always_ff @(posedge g_clk) begin
        if (i_reset) begin
            mtime <= '0;
        end else if (wr_ok && i_mmio_off == `MTIME_LO_OFF) begin
            mtime[31:0] <= merge_lanes(mtime[31:0], i_mmio_wdata, i_mmio_strb);
        end else if (wr_ok && i_mmio_off == `MTIME_HI_OFF) begin
            mtime[63:32] <= merge_lanes(mtime[63:32], i_mmio_wdata, i_mmio_strb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_reset) begin
            mtimecmp <= `MTIMECMP_RESET;
        end else if (wr_ok && i_mmio_off == `MTIMECMP_LO_OFF) begin
            mtimecmp[31:0] <= merge_lanes(mtimecmp[31:0], i_mmio_wdata, i_mmio_strb);
        end else if (wr_ok && i_mmio_off == `MTIMECMP_HI_OFF) begin
            mtimecmp[63:32] <= merge_lanes(mtimecmp[63:32], i_mmio_wdata, i_mmio_strb);
        end
    end

    // ----------------------------------------
    // Response and interrupt level
    always_ff @(posedge g_clk) begin
        if (i_reset) begin
            o_mmio_gnt  <= 1'b0;
            o_mmio_err  <= 1'b0;
            o_timer_int <= 1'b0;
        end else begin
            o_mmio_gnt  <= access;               // Exactly one cycle later
            o_mmio_err  <= access && misaligned;
            o_timer_int <= mtime >= mtimecmp;    // Sees a write after its gnt
        end
    end

    always_ff @(posedge g_clk) begin
        if (access) begin
            o_mmio_rdata <= rd_word;
        end
    end

    // ----------------------------------------
    // Assertions
    a_gnt_pulse: assert property (@(posedge g_clk) disable iff (i_reset)
        o_mmio_gnt |=> !o_mmio_gnt)
        else $error("MMIO gnt high two cycles running");

endmodule

//--- hdl/core_interrupts.sv
// Machine interrupt controller. Latches the pending lines, masks them with
// the enables, picks external, then software, then timer, and presents the
// cause and trap vector until the pipeline acknowledges them.
`timescale 1ns/1ps
`include "core_params.svh"

module core_interrupts (
    input  logic               g_clk,
    input  logic               i_reset,
    input  logic               i_int_sw,    // Software interrupt line
    input  logic               i_int_ext,   // External interrupt line
    input  logic               i_timer_int, // From the timer block
    input  core_pkg::int_cfg_t i_cfg,       // Enables and mtvec
    input  logic               i_int_ack,   // Pulse, interrupt taken
    output core_pkg::int_out_t o_int
);

    import core_pkg::*;

    logic [2:0]  pend_q;  // {ext, sw, timer}
    logic [2:0]  live;    // Pending and enabled
    logic [31:0] code;    // Winning cause code
    logic [31:0] base;    // Byte address of the vector table
    int_out_t    nxt;     // Candidate output

    // ----------------------------------------
    // Pending latches
    always_ff @(posedge g_clk) begin
        if (i_reset) begin
            pend_q <= '0;
        end else begin
            pend_q <= {i_int_ext, i_int_sw, i_timer_int};
        end
    end

    assign live = pend_q & {i_cfg.mie_meie, i_cfg.mie_msie, i_cfg.mie_mtie}
                & {3{i_cfg.mstatus_mie}};

    // ----------------------------------------
    // Priority and vector
    always_comb begin
        if (live[2]) begin
            code = `INT_CODE_MEI;
        end else if (live[1]) begin
            code = `INT_CODE_MSI;
        end else begin
            code = `INT_CODE_MTI;
        end
    end

    assign base = {i_cfg.mtvec.f.base, 2'b00};

    always_comb begin
        nxt.request = |live;
        nxt.cause   = nxt.request ? (32'h8000_0000 | code) : '0;
        nxt.tvec    = (i_cfg.mtvec.f.mode == `MTVEC_MODE_VEC) ? base + (code << 2) : base;
    end

    // ----------------------------------------
    // Output register, frozen while an unacked request stands
    always_ff @(posedge g_clk) begin
        if (i_reset) begin
            o_int <= '0;
        end else if (!o_int.request || i_int_ack) begin
            o_int <= nxt; // Re-evaluated the cycle after ack
        end
    end

    // ----------------------------------------
    // Assertions
    a_hold: assert property (@(posedge g_clk) disable iff (i_reset)
        o_int.request && !i_int_ack |=> $stable(o_int.cause) && $stable(o_int.tvec))
        else $error("interrupt cause or vector moved before ack");

endmodule

//--- hdl/core_mmio_mux.sv
// Data bus splitter. Requests inside the MMIO window go to the timer block,
// all others pass straight to the external bus. The response of the
// selected side is returned to the pipeline in the same cycle.
`timescale 1ns/1ps
`include "core_params.svh"

module core_mmio_mux (
    input  logic                   g_clk,
    input  logic                   i_reset,
    input  core_pkg::mem_req_t     i_req,        // From the pipeline
    output core_pkg::mem_rsp_t     o_rsp,        // To the pipeline
    output core_pkg::mem_req_t     o_ext_req,    // To external memory
    input  core_pkg::mem_rsp_t     i_ext_rsp,    // From external memory
    output logic                   o_mmio_req,   // Timer block strobe
    output logic                   o_mmio_wen,
    output logic [3:0]             o_mmio_off,   // Offset inside window
    output logic [`MEM_DATA_W-1:0] o_mmio_wdata,
    output logic [`MEM_STRB_W-1:0] o_mmio_strb,
    input  logic                   i_mmio_gnt,
    input  logic                   i_mmio_err,
    input  logic [`MEM_DATA_W-1:0] i_mmio_rdata
);

    import core_pkg::*;

    logic     in_window; // Held address hits the timer block
    mem_rsp_t mmio_rsp;  // Timer response in bus form

    // ----------------------------------------
    // Address decode
    assign in_window = (i_req.addr & `MMIO_BASE_MASK) == `MMIO_BASE_ADDR;

    // ----------------------------------------
    // Request routing
    always_comb begin
        o_ext_req     = i_req;                    // Payload passes unchanged
        o_ext_req.req = i_req.req && !in_window;  // Only req is steered
    end

    assign o_mmio_req   = i_req.req && in_window;
    assign o_mmio_wen   = i_req.wen;
    assign o_mmio_off   = i_req.addr[3:0];        // Low nibble picks register
    assign o_mmio_wdata = i_req.wdata;
    assign o_mmio_strb  = i_req.strb;

    // ----------------------------------------
    // Response select
    assign mmio_rsp.gnt   = i_mmio_gnt;
    assign mmio_rsp.err   = i_mmio_err;
    assign mmio_rsp.rdata = i_mmio_rdata;

    // Address is stable until gnt, so the decode still holds in the gnt cycle
    assign o_rsp = in_window ? mmio_rsp : i_ext_rsp;

    // ----------------------------------------
    // Assertions

    // Pipeline keeps the request and its address until it is granted
    a_req_held: assert property (@(posedge g_clk) disable iff (i_reset)
        i_req.req && !o_rsp.gnt |=> i_req.req && $stable(i_req.addr))
        else $error("data request dropped or moved before gnt");

    // External memory and timer block never answer together
    a_one_gnt: assert property (@(posedge g_clk) disable iff (i_reset)
        !(i_ext_rsp.gnt && i_mmio_gnt))
        else $error("external and MMIO grant in one cycle");

endmodule

//--- hdl/core_params.svh
// Fixed widths, MMIO window, timer register map and interrupt codes.
// Included by the package and by every RTL module that needs a constant.
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ----------------------------------------
// Data memory bus
`define MEM_ADDR_W      32                      // Address bits
`define MEM_DATA_W      32                      // Data bits
`define MEM_STRB_W      4                       // One strobe per byte lane

// ----------------------------------------
// MMIO window and timer register offsets
`define MMIO_BASE_ADDR  32'h0001_0000           // Timer block base
`define MMIO_BASE_MASK  32'hFFFF_FFF0           // 16 byte window
`define MTIME_LO_OFF    4'h0                    // mtime bits 31:0
`define MTIME_HI_OFF    4'h4                    // mtime bits 63:32
`define MTIMECMP_LO_OFF 4'h8                    // mtimecmp bits 31:0
`define MTIMECMP_HI_OFF 4'hC                    // mtimecmp bits 63:32

// ----------------------------------------
// Interrupt codes and reset values
`define INT_CODE_MSI    32'd3                   // Machine software
`define INT_CODE_MTI    32'd7                   // Machine timer
`define INT_CODE_MEI    32'd11                  // Machine external
`define MTVEC_MODE_VEC  2'd1                    // Vectored mode, 0 is direct
`define MTIMECMP_RESET  64'hFFFF_FFFF_FFFF_FFFF // Timer never fires out of reset

`endif

//--- hdl/core_pkg.sv
// Shared bus and interrupt types for the data-memory and interrupt slice.
// Modules name these with core_pkg:: in their ports and import the package
// in their bodies where they need more.
`include "core_params.svh"

package core_pkg;

    // ----------------------------------------
    // Data memory bus, req/gnt handshake
    typedef struct packed {
        logic                   req;   // Request held until gnt
        logic [`MEM_ADDR_W-1:0] addr;  // Byte address
        logic                   wen;   // Write when set
        logic [`MEM_STRB_W-1:0] strb;  // Byte lane enables
        logic [`MEM_DATA_W-1:0] wdata; // Write data
    } mem_req_t;

    typedef struct packed {
        logic                   gnt;   // One cycle pulse
        logic                   err;   // Valid with gnt only
        logic [`MEM_DATA_W-1:0] rdata; // Valid with gnt only
    } mem_rsp_t;

    // ----------------------------------------
    // Trap vector register, raw word or decoded fields
    typedef struct packed {
        logic [29:0] base; // Word aligned base
        logic [1:0]  mode; // 0 direct, 1 vectored
    } mtvec_fields_t;

    typedef union packed {
        logic [31:0]   raw;
        mtvec_fields_t f;
    } mtvec_t;

    // ----------------------------------------
    // Interrupt configuration and output
    typedef struct packed {
        logic   mstatus_mie; // Global enable
        logic   mie_meie;    // External enable
        logic   mie_mtie;    // Timer enable
        logic   mie_msie;    // Software enable
        mtvec_t mtvec;
    } int_cfg_t;

    typedef struct packed {
        logic        request; // Level, held until ack
        logic [31:0] cause;   // Bit 31 set plus code
        logic [31:0] tvec;    // Trap target address
    } int_out_t;

endpackage

//--- hdl/core_platform_top.sv
// Data-memory and interrupt platform. Splits the pipeline data bus between
// external memory and the timer block, and feeds the timer, software and
// external lines to the interrupt controller.
`timescale 1ns/1ps
`include "core_params.svh"

module core_platform_top (
    input  logic               g_clk,
    input  logic               i_reset,
    input  core_pkg::mem_req_t i_dmem,     // Pipeline data request
    output core_pkg::mem_rsp_t o_dmem,     // Pipeline data response
    output core_pkg::mem_req_t o_ext_dmem, // External memory request
    input  core_pkg::mem_rsp_t i_ext_dmem, // External memory response
    input  logic               i_int_sw,
    input  logic               i_int_ext,
    input  core_pkg::int_cfg_t i_int_cfg,  // Enables and mtvec
    input  logic               i_int_ack,
    output core_pkg::int_out_t o_int
);

    // ----------------------------------------
    // Mux to timer block
    logic                   mmio_req;
    logic                   mmio_wen;
    logic [3:0]             mmio_off;
    logic [`MEM_DATA_W-1:0] mmio_wdata;
    logic [`MEM_STRB_W-1:0] mmio_strb;
    logic                   mmio_gnt;
    logic                   mmio_err;
    logic [`MEM_DATA_W-1:0] mmio_rdata;
    logic                   timer_int;  // Timer level to the controller

    core_mmio_mux u_mmio_mux (
        .g_clk        (g_clk),
        .i_reset      (i_reset),
        .i_req        (i_dmem),
        .o_rsp        (o_dmem),
        .o_ext_req    (o_ext_dmem),
        .i_ext_rsp    (i_ext_dmem),
        .o_mmio_req   (mmio_req),
        .o_mmio_wen   (mmio_wen),
        .o_mmio_off   (mmio_off),
        .o_mmio_wdata (mmio_wdata),
        .o_mmio_strb  (mmio_strb),
        .i_mmio_gnt   (mmio_gnt),
        .i_mmio_err   (mmio_err),
        .i_mmio_rdata (mmio_rdata)
    );

    core_counters u_counters (
        .g_clk        (g_clk),
        .i_reset      (i_reset),
        .i_mmio_req   (mmio_req),
        .i_mmio_wen   (mmio_wen),
        .i_mmio_off   (mmio_off),
        .i_mmio_wdata (mmio_wdata),
        .i_mmio_strb  (mmio_strb),
        .o_mmio_gnt   (mmio_gnt),
        .o_mmio_err   (mmio_err),
        .o_mmio_rdata (mmio_rdata),
        .o_timer_int  (timer_int)
    );

    core_interrupts u_interrupts (
        .g_clk       (g_clk),
        .i_reset     (i_reset),
        .i_int_sw    (i_int_sw),
        .i_int_ext   (i_int_ext),
        .i_timer_int (timer_int),
        .i_cfg       (i_int_cfg),
        .i_int_ack   (i_int_ack),
        .o_int       (o_int)
    );

    // Controller decodes only direct and vectored, modes 2 and 3 are reserved
    a_mtvec_mode: assert property (@(posedge g_clk) disable iff (i_reset)
        i_int_cfg.mtvec.raw[1:0] < 2'd2)
        else $error("reserved mtvec mode");

endmodule

//--- project.f
+incdir+hdl
hdl/core_pkg.sv
hdl/core_mmio_mux.sv
hdl/core_counters.sv
hdl/core_interrupts.sv
hdl/core_platform_top.sv
verification/tb_core_platform.sv

//--- verification/tb_core_platform.sv
// Directed testbench for the data-memory and interrupt platform.
// Plays the pipeline on the data bus and models external memory with a
// random grant delay. Run through project.f with tb_core_platform as top.
`timescale 1ns/1ps

module tb_core_platform;

    import core_pkg::*;

    localparam int HALF = 20;                    // 40 ns clock
    localparam int T1_CYC = 200;                 // Pass-through
    localparam int T2_CYC = 40;                  // mtimecmp access
    localparam int T3_CYC = 80;                  // mtime count
    localparam int T4_CYC = 150;                 // Timer interrupt
    localparam int T5_CYC = 150;                 // Priority and masking
    localparam int RUN_CYC = 16 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC;
    localparam logic [31:0] WIN = 32'h0001_0000; // Timer block base

    logic g_clk, i_reset, i_int_sw, i_int_ext, i_int_ack;
    mem_req_t i_dmem, o_ext_dmem;
    mem_rsp_t o_dmem, i_ext_dmem;
    int_cfg_t i_int_cfg;
    int_out_t o_int;

    logic [31:0] mem [16];                       // External memory model
    logic [31:0] exp_mem [16];                   // Expected contents
    logic        ext_busy;
    int          ext_delay;
    int          errors = 0;
    int          checks = 0;
    longint      cyc = 0;

    core_platform_top u_dut (
        .g_clk(g_clk), .i_reset(i_reset), .i_dmem(i_dmem), .o_dmem(o_dmem),
        .o_ext_dmem(o_ext_dmem), .i_ext_dmem(i_ext_dmem), .i_int_sw(i_int_sw),
        .i_int_ext(i_int_ext), .i_int_cfg(i_int_cfg), .i_int_ack(i_int_ack),
        .o_int(o_int)
    );

    initial begin
        g_clk = 1'b0;
        forever #HALF g_clk = ~g_clk;
    end

    always @(posedge g_clk) cyc++;

    // ----------------------------------------
    // External memory with a delay picked when a request is first seen
    always @(posedge g_clk) begin
        if (i_ext_dmem.gnt) begin
            if (o_ext_dmem.wen) begin
                for (int i = 0; i < 4; i++) begin
                    if (o_ext_dmem.strb[i]) begin
                        mem[o_ext_dmem.addr[5:2]][8*i +: 8] = o_ext_dmem.wdata[8*i +: 8];
                    end
                end
            end
            ext_busy = 1'b0;
        end else if (ext_busy) begin
            ext_delay--;                         // Counts down to the grant
        end else if (o_ext_dmem.req) begin
            ext_busy  = 1'b1;
            ext_delay = $urandom % 4;            // 0 to 3 extra cycles
        end
    end

    always @(negedge g_clk) begin
        i_ext_dmem = '0;
        if (ext_busy && ext_delay == 0) begin
            i_ext_dmem.gnt   = 1'b1;
            i_ext_dmem.rdata = mem[o_ext_dmem.addr[5:2]];
        end
    end

    // ----------------------------------------
    // Check helpers
    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_range(input string name, input logic [31:0] lo,
                               input logic [31:0] hi, input logic [31:0] act);
        checks++;
        assert (act >= lo && act <= hi) else begin
            errors++;
            $display("Fail %s: expected %h to %h, actual %h", name, lo, hi, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                          input logic [3:0] strb);
        logic [31:0] r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) r[8*i +: 8] = new_w[8*i +: 8];
        end
        return r;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge g_clk);
    endtask

    // One bus transfer sampled 1 ns before each rising edge
    task automatic bus_access(input logic [31:0] addr, input logic wen, input logic [3:0] strb,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int lat);
        logic in_win;
        logic done;
        in_win = (addr & 32'hFFFF_FFF0) == WIN;
        done   = 1'b0;
        lat    = 0;
        @(negedge g_clk);
        i_dmem = '{req: 1'b1, addr: addr, wen: wen, strb: strb, wdata: wdata};
        while (!done) begin
            #(HALF - 1);
            if (in_win) begin
                check_true(!o_ext_dmem.req, "external req raised for a window address");
            end else begin
                check_true(o_ext_dmem == i_dmem, "request not passed through unchanged");
            end
            if (o_dmem.gnt) begin
                done  = 1'b1;
                rdata = o_dmem.rdata;
                err   = o_dmem.err;
            end else begin
                lat++;
                check_true(lat < 20, "no gnt within 20 cycles");
                if (lat >= 20) done = 1'b1;
                @(negedge g_clk);
            end
        end
        @(negedge g_clk);
        i_dmem = '0;                             // Drop req the cycle after gnt
        #(HALF - 1);
        check_true(!o_ext_dmem.req, "external req still high after gnt");
    endtask

    task automatic wait_request(input int limit);
        int n;
        n = 0;
        while (!o_int.request && n < limit) begin
            @(negedge g_clk);
            #(HALF - 1);
            n++;
        end
        check_true(o_int.request, "interrupt request did not rise");
    endtask

    task automatic pulse_ack();
        @(negedge g_clk);
        i_int_ack = 1'b1;
        @(negedge g_clk);
        i_int_ack = 1'b0;
        #(HALF - 1);
    endtask

    // ----------------------------------------
    // Directed tests
    task automatic test_passthrough();
        logic [31:0] a, d, rd;
        logic [3:0]  s;
        logic        e;
        int          lat;
        for (int k = 0; k < 24; k++) begin
            a = 32'h0000_2000 | ($urandom & 32'h3C);
            d = $urandom;
            s = 4'($urandom);
            if ($urandom % 2) begin
                bus_access(a, 1'b1, s, d, rd, e, lat);
                exp_mem[a[5:2]] = merge(exp_mem[a[5:2]], d, s);
            end else begin
                bus_access(a, 1'b0, 4'hF, 32'h0, rd, e, lat);
                check_val("passthrough read", exp_mem[a[5:2]], rd);
                check_val("passthrough err", 32'h0, {31'h0, e});
            end
        end
    endtask

    task automatic test_mtimecmp();
        logic [31:0] rd;
        logic        e;
        int          lat;
        bus_access(WIN + 32'h8, 1'b1, 4'hF, 32'h1234_5678, rd, e, lat);
        check_val("mtimecmp write latency", 32'd1, lat);
        bus_access(WIN + 32'hC, 1'b1, 4'hF, 32'h7EAD_BEEF, rd, e, lat);
        bus_access(WIN + 32'h8, 1'b0, 4'hF, 32'h0, rd, e, lat);
        check_val("mtimecmp lo read", 32'h1234_5678, rd);
        check_val("mtimecmp read latency", 32'd1, lat);
        bus_access(WIN + 32'hC, 1'b0, 4'hF, 32'h0, rd, e, lat);
        check_val("mtimecmp hi read", 32'h7EAD_BEEF, rd);
        bus_access(WIN + 32'h9, 1'b1, 4'hF, 32'hFFFF_FFFF, rd, e, lat);
        check_val("misaligned err", 32'd1, {31'h0, e});
        check_val("misaligned rdata", 32'h0, rd);
        bus_access(WIN + 32'h8, 1'b0, 4'hF, 32'h0, rd, e, lat);
        check_val("mtimecmp after misaligned", 32'h1234_5678, rd);
    endtask

    task automatic test_mtime();
        logic [31:0] rd, r1, r2;
        logic        e;
        int          lat;
        longint      t_wr;
        longint      t_rd;
        bus_access(WIN + 32'h4, 1'b1, 4'hF, 32'h0, rd, e, lat);
        bus_access(WIN + 32'h0, 1'b1, 4'hF, 32'h0000_1000, rd, e, lat);
        t_wr = cyc;
        idle(5);
        bus_access(WIN + 32'h0, 1'b0, 4'hF, 32'h0, r1, e, lat);
        t_rd = cyc;
        check_range("mtime after write", 32'h0000_1001,
                    32'h0000_1000 + 32'(t_rd - t_wr), r1);
        bus_access(WIN + 32'h0, 1'b0, 4'hF, 32'h0, r2, e, lat);
        check_range("mtime second read", r1 + 32'd1, 32'hFFFF_FFFF, r2);
    endtask

    task automatic test_timer_int();
        logic [31:0] rd, now;
        logic        e;
        int          lat;
        @(negedge g_clk);
        i_int_cfg = '0;
        i_int_cfg.mstatus_mie = 1'b1;
        i_int_cfg.mie_mtie    = 1'b1;
        i_int_cfg.mtvec.raw   = 32'h0000_0800;   // Direct mode
        bus_access(WIN + 32'hC, 1'b1, 4'hF, 32'h0, rd, e, lat);
        bus_access(WIN + 32'h0, 1'b0, 4'hF, 32'h0, now, e, lat);
        bus_access(WIN + 32'h8, 1'b1, 4'hF, now + 32'd20, rd, e, lat);
        check_true(!o_int.request, "timer request before mtimecmp reached");
        wait_request(60);
        check_val("timer cause", 32'h8000_0007, o_int.cause);
        check_val("timer tvec", 32'h0000_0800, o_int.tvec);
        bus_access(WIN + 32'hC, 1'b1, 4'hF, 32'hFFFF_FFFF, rd, e, lat);
        idle(3);                                 // Level and pending settle
        pulse_ack();
        check_val("timer request after ack", 32'h0, {31'h0, o_int.request});
    endtask

    task automatic test_priority();
        @(negedge g_clk);
        i_int_cfg = '0;
        i_int_cfg.mstatus_mie = 1'b1;
        i_int_cfg.mie_meie    = 1'b1;
        i_int_cfg.mie_msie    = 1'b1;
        i_int_cfg.mtvec.raw   = 32'h0000_1000 | 32'd1; // Vectored
        @(negedge g_clk);
        i_int_sw  = 1'b1;
        i_int_ext = 1'b1;
        wait_request(20);
        check_val("ext cause", 32'h8000_000B, o_int.cause);
        check_val("ext tvec", 32'h0000_1000 + 32'd44, o_int.tvec);
        @(negedge g_clk);
        i_int_ext = 1'b0;
        idle(2);
        pulse_ack();
        check_val("sw cause", 32'h8000_0003, o_int.cause);
        check_val("sw tvec", 32'h0000_1000 + 32'd12, o_int.tvec);
        @(negedge g_clk);
        i_int_cfg.mstatus_mie = 1'b0;            // Global disable
        i_int_ext = 1'b1;
        pulse_ack();
        for (int k = 0; k < 10; k++) begin
            idle(1);
            #(HALF - 1);
            check_val("masked request", 32'h0, {31'h0, o_int.request});
        end
        @(negedge g_clk);
        i_int_sw  = 1'b0;
        i_int_ext = 1'b0;
    endtask

    // ----------------------------------------
    // Watchdog
    initial begin
        #(longint'(RUN_CYC) * 2 * HALF);
        $display("Watchdog expired, tests did not finish in %0d cycles", RUN_CYC);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h030f_586a));
        i_reset   = 1'b1;
        i_dmem    = '0;
        i_ext_dmem = '0;
        i_int_sw  = 1'b0;
        i_int_ext = 1'b0;
        i_int_ack = 1'b0;
        i_int_cfg = '0;
        ext_busy  = 1'b0;
        ext_delay = 0;
        for (int i = 0; i < 16; i++) begin
            mem[i]     = (32'h0000_2000 + 4 * i) ^ 32'h5A5A_A5A5; // Address based fill
            exp_mem[i] = mem[i];
        end
        repeat (16) @(negedge g_clk);
        i_reset = 1'b0;
        test_passthrough();
        test_mtimecmp();
        test_mtime();
        test_timer_int();
        test_priority();
        idle(2);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
